/* Makefile */
TOP := tb_ad7768_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* ad7768_interleave.sv */
// ********************
// one sample per cycle, lane 0 first, NUM_LANES cycles per frame
// no back-pressure, the sink takes every valid cycle
// a new frame_valid restarts the burst from lane 0
// ********************

`timescale 1ns/1ps

module ad7768_interleave #(
  parameter int NUM_LANES = 8
) (
  input  logic                                         adc_clk,
  input  logic                                         arst_n,
  input  logic                                         frame_valid,
  input  logic [NUM_LANES-1:0][ad7768_pkg::WORD_W-1:0] frame_words,
  output logic                                         adc_valid,
  output ad7768_pkg::sample_t                          adc_sample,
  output logic                                         hdr_valid,
  output logic [ad7768_pkg::CH_W-1:0]                  hdr_ch,
  output ad7768_pkg::hdr_t                             hdr
);

  import ad7768_pkg::*;

  localparam logic [CH_W-1:0] LAST_LANE = CH_W'(NUM_LANES - 1);

  emit_state_e                      state;
  logic [CH_W-1:0]                  lane_idx;
  logic [NUM_LANES-1:0][WORD_W-1:0] word_buf;
  logic [WORD_W-1:0]                cur_word;

  // ********************
  // frame buffer
  // ********************

  // held for the whole burst, the next frame is far behind
  always_ff @(posedge adc_clk) begin
    if (frame_valid) begin
      word_buf <= frame_words;
    end
  end

  // ********************
  // emit fsm
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      lane_idx <= '0;
    end else if (frame_valid) begin
      state    <= ST_EMIT;
      lane_idx <= '0;
    end else begin
      case (state)
        ST_EMIT: begin
          if (lane_idx == LAST_LANE) begin
            state    <= ST_IDLE;
            lane_idx <= '0;
          end else begin
            lane_idx <= lane_idx + 1'b1;
          end
        end
        default: begin
          state    <= ST_IDLE;
          lane_idx <= '0;
        end
      endcase
    end
  end

  // ********************
  // sample and header split
  // ********************

  assign cur_word = word_buf[lane_idx];

  assign adc_valid          = (state == ST_EMIT);
  assign adc_sample.channel = lane_idx;
  // sign extend the 24-bit sample
  assign adc_sample.data    = {{(WORD_W - DATA_W){cur_word[DATA_W-1]}},
                               cur_word[DATA_W-1:0]};

  // header goes to the status block alongside each sample
  assign hdr_valid = adc_valid;
  assign hdr_ch    = lane_idx;
  assign hdr.err   = cur_word[HDR_ERR_BIT];
  assign hdr.id    = cur_word[HDR_ID_LSB +: CH_W];

endmodule

/* ad7768_lane_deser.sv */
// ********************
// drdy and lanes pass one register stage before the counter
// only runs of exactly WORD_W bits or more give a frame
// bits past WORD_W are dropped until drdy falls
// frame_valid comes 2 cycles after the 32nd bit at the pins
// ********************

`timescale 1ns/1ps

module ad7768_lane_deser #(
  parameter int NUM_LANES = 8
) (
  input  logic                                         adc_clk,
  input  logic                                         arst_n,
  input  logic                                         drdy,
  input  logic [NUM_LANES-1:0]                         lane_data,
  output logic                                         frame_valid,
  output logic [NUM_LANES-1:0][ad7768_pkg::WORD_W-1:0] frame_words
);

  import ad7768_pkg::*;

  localparam logic [BIT_CNT_W-1:0] FULL_CNT = BIT_CNT_W'(WORD_W);

  logic                             drdy_q;
  logic [NUM_LANES-1:0]             lane_q;
  logic [BIT_CNT_W-1:0]             bit_cnt;
  logic                             shift_en;
  logic                             frame_done;
  logic [NUM_LANES-1:0][WORD_W-1:0] shift_words;

  // ********************
  // input stage
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      drdy_q <= 1'b0;
    end else begin
      drdy_q <= drdy;
    end
  end

  always_ff @(posedge adc_clk) begin
    lane_q <= lane_data;
  end

  // ********************
  // bit counter
  // ********************

  // stops one past full so the done compare fires only once per frame
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (!drdy_q) begin
      bit_cnt <= '0;
    end else if (bit_cnt <= FULL_CNT) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign shift_en   = drdy_q && (bit_cnt < FULL_CNT);
  assign frame_done = (bit_cnt == FULL_CNT);

  // ********************
  // per-lane shifters
  // ********************

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    logic [WORD_W-1:0] shift_q;

    // msb arrives first
    always_ff @(posedge adc_clk) begin
      if (shift_en) begin
        shift_q <= {shift_q[WORD_W-2:0], lane_q[i]};
      end
    end

    assign shift_words[i] = shift_q;
  end

  // ********************
  // frame output
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= frame_done;
    end
  end

  // shifters hold still once full, so this copy is the whole frame
  always_ff @(posedge adc_clk) begin
    if (frame_done) begin
      frame_words <= shift_words;
    end
  end

endmodule

/* ad7768_pkg.sv */
// ********************
// shared widths, header layout and types of the adc receive path
// one channel per lane, 32-bit word per frame, msb first on the wire
// lane counts above MAX_LANES do not fit the 3-bit channel id
// ********************

package ad7768_pkg;

  // ********************
  // word layout
  // ********************

  // bits per lane per frame
  localparam int WORD_W      = 32;
  // two's complement sample in the low bits
  localparam int DATA_W      = 24;
  localparam int CH_W        = 3;
  localparam int MAX_LANES   = 8;

  // header byte fields
  localparam int HDR_ERR_BIT = 31;
  localparam int HDR_ID_LSB  = 24;

  // has to reach WORD_W + 1
  localparam int BIT_CNT_W   = 6;

  // ********************
  // structs
  // ********************

  // one interleaved output sample
  typedef struct packed {
    logic [CH_W-1:0]   channel;
    logic [WORD_W-1:0] data;
  } sample_t;

  // decoded header of one lane word
  typedef struct packed {
    logic            err;
    logic [CH_W-1:0] id;
  } hdr_t;

  // sticky flags of one channel
  typedef struct packed {
    logic err;
    logic id_fault;
  } ch_status_t;

  // ********************
  // state machines
  // ********************

  typedef enum logic {
    ST_IDLE,
    ST_EMIT
  } emit_state_e;

  typedef enum logic [1:0] {
    CLR_IDLE,
    CLR_ACK,
    CLR_WAIT_LOW
  } clr_state_e;

endpackage

/* ad7768_rx.sv */
// ********************
// receive path top, all logic on adc_clk
// NUM_LANES from 1 to MAX_LANES, one channel per lane
// first sample 3 cycles after the 32nd bit is sampled
// ********************

`timescale 1ns/1ps

module ad7768_rx #(
  parameter int NUM_LANES = 8
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n,
  input  logic                                  drdy,
  input  logic [NUM_LANES-1:0]                  lane_data,
  input  logic                                  clr_req,
  input  logic [NUM_LANES-1:0]                  clr_mask,
  output logic                                  adc_valid,
  output ad7768_pkg::sample_t                   adc_sample,
  output ad7768_pkg::ch_status_t [NUM_LANES-1:0] ch_status,
  output logic                                  clr_ack
);

  import ad7768_pkg::*;

  logic                             frame_valid;
  logic [NUM_LANES-1:0][WORD_W-1:0] frame_words;
  logic                             hdr_valid;
  logic [CH_W-1:0]                  hdr_ch;
  hdr_t                             hdr;

  // lane count has to fit the channel id
  if (NUM_LANES < 1 || NUM_LANES > MAX_LANES) begin : g_bad_lanes
    $error("NUM_LANES out of range");
  end

  // ********************
  // datapath
  // ********************

  ad7768_lane_deser #(
    .NUM_LANES (NUM_LANES)
  ) i_lane_deser (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .drdy        (drdy),
    .lane_data   (lane_data),
    .frame_valid (frame_valid),
    .frame_words (frame_words)
  );

  ad7768_interleave #(
    .NUM_LANES (NUM_LANES)
  ) i_interleave (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .frame_valid (frame_valid),
    .frame_words (frame_words),
    .adc_valid   (adc_valid),
    .adc_sample  (adc_sample),
    .hdr_valid   (hdr_valid),
    .hdr_ch      (hdr_ch),
    .hdr         (hdr)
  );

  // status flags and clear handshake
  ad7768_status #(
    .NUM_LANES (NUM_LANES)
  ) i_status (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .hdr_valid (hdr_valid),
    .hdr_ch    (hdr_ch),
    .hdr       (hdr),
    .clr_req   (clr_req),
    .clr_mask  (clr_mask),
    .clr_ack   (clr_ack),
    .ch_status (ch_status)
  );

endmodule

/* ad7768_rx_sva.sv */
// ********************
// handshake and stream rules, bound into the status block
// hdr_valid and hdr_ch follow adc_valid and the sample channel
// ********************

`timescale 1ns/1ps

module ad7768_rx_sva #(
  parameter int NUM_LANES = 8
) (
  input logic                        adc_clk,
  input logic                        arst_n,
  input logic                        clr_req,
  input logic                        clr_ack,
  input logic                        hdr_valid,
  input logic [ad7768_pkg::CH_W-1:0] hdr_ch
);

  import ad7768_pkg::*;

  localparam logic [CH_W-1:0] LAST_CH = CH_W'(NUM_LANES - 1);

  // ack only answers a request
  ack_rise: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $rose(clr_ack) |-> $past(clr_req))
    else $error("clr_ack rose while clr_req was low");

  ack_fall: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $fell(clr_ack) |-> !$past(clr_req))
    else $error("clr_ack fell while clr_req was still high");

  // bursts open on lane 0 and step by one
  burst_start: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $rose(hdr_valid) |-> (hdr_ch == '0))
    else $error("burst did not start on channel 0");

  burst_step: assert property (@(posedge adc_clk) disable iff (!arst_n)
    (hdr_valid && hdr_ch != LAST_CH) |=> (hdr_valid && hdr_ch == CH_W'($past(hdr_ch) + 1'b1)))
    else $error("burst broke off or skipped a channel");

endmodule

bind ad7768_status ad7768_rx_sva #(
  .NUM_LANES (NUM_LANES)
) i_rx_sva (
  .adc_clk   (adc_clk),
  .arst_n    (arst_n),
  .clr_req   (clr_req),
  .clr_ack   (clr_ack),
  .hdr_valid (hdr_valid),
  .hdr_ch    (hdr_ch)
);

/* ad7768_status.sv */
// ********************
// sticky per-channel flags, set one cycle after hdr_valid
// clear runs as a four-phase req/ack, clr_mask stable while clr_req is high
// a set and a clear in the same cycle leave the flag set
// ********************

`timescale 1ns/1ps

module ad7768_status #(
  parameter int NUM_LANES = 8
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n,
  input  logic                                  hdr_valid,
  input  logic [ad7768_pkg::CH_W-1:0]           hdr_ch,
  input  ad7768_pkg::hdr_t                      hdr,
  input  logic                                  clr_req,
  input  logic [NUM_LANES-1:0]                  clr_mask,
  output logic                                  clr_ack,
  output ad7768_pkg::ch_status_t [NUM_LANES-1:0] ch_status
);

  import ad7768_pkg::*;

  clr_state_e clr_state;
  logic       clr_now;
  logic       id_mismatch;

  // ********************
  // clear handshake
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_state <= CLR_IDLE;
    end else begin
      case (clr_state)
        CLR_IDLE: begin
          if (clr_req) begin
            clr_state <= CLR_ACK;
          end
        end
        // single cycle, the masked flags are cleared here
        CLR_ACK: begin
          if (clr_req) begin
            clr_state <= CLR_WAIT_LOW;
          end else begin
            clr_state <= CLR_IDLE;
          end
        end
        CLR_WAIT_LOW: begin
          if (!clr_req) begin
            clr_state <= CLR_IDLE;
          end
        end
        default: begin
          clr_state <= CLR_IDLE;
        end
      endcase
    end
  end

  assign clr_now = (clr_state == CLR_ACK);
  // ack stays up until req has been seen low
  assign clr_ack = (clr_state != CLR_IDLE);

  // ********************
  // flags
  // ********************

  // each lane carries its own channel, so id must equal the lane index
  assign id_mismatch = (hdr.id != hdr_ch);

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_ch
    logic       hit;
    logic       clr_ch;
    ch_status_t flags_q;

    assign hit    = hdr_valid && (hdr_ch == CH_W'(i));
    assign clr_ch = clr_now && clr_mask[i];

    always_ff @(posedge adc_clk or negedge arst_n) begin
      if (!arst_n) begin
        flags_q <= '0;
      end else begin
        flags_q.err      <= (hit && hdr.err) || (flags_q.err && !clr_ch);
        flags_q.id_fault <= (hit && id_mismatch) || (flags_q.id_fault && !clr_ch);
      end
    end

    assign ch_status[i] = flags_q;
  end

endmodule

/* all.f */
ad7768_pkg.sv
ad7768_lane_deser.sv
ad7768_interleave.sv
ad7768_status.sv
ad7768_rx.sv
ad7768_rx_sva.sv
tb_ad7768_rx.sv

/* tb_ad7768_rx.sv */
// ********************
// testbench for the adc receive path with NUM_LANES at 8
// fixed entries first, then LFSR random frames, one entry at a time
// stops at the first error
// ********************

`timescale 1ns/1ps

module tb_ad7768_rx;

  import ad7768_pkg::*;

  localparam int NUM_LANES  = 8;
  localparam int N_FIXED    = 6;
  localparam int N_ENTRIES  = N_FIXED + 20;
  localparam int MAX_CYCLES = 8 + N_ENTRIES * 45 + 100;

  // one row of the stimulus table
  typedef struct packed {
    logic [NUM_LANES-1:0][WORD_W-1:0] words;
    logic [BIT_CNT_W-1:0]             len;
    logic                             clr_en;
    logic [NUM_LANES-1:0]             clr_mask;
  } entry_t;

  logic                             adc_clk = 1'b0;
  logic                             arst_n;
  logic                             drdy;
  logic [NUM_LANES-1:0]             lane_data;
  logic                             clr_req;
  logic [NUM_LANES-1:0]             clr_mask;
  logic                             adc_valid;
  sample_t                          adc_sample;
  ch_status_t [NUM_LANES-1:0]       ch_status;
  logic                             clr_ack;

  entry_t      table_q [N_ENTRIES];
  string       names [N_ENTRIES];
  sample_t     sample_q [$];
  ch_status_t  exp_flags [NUM_LANES];
  logic [31:0] lfsr = 32'heb33_2648;
  int          cycle_cnt = 0;

  always #50 adc_clk = ~adc_clk;

  ad7768_rx #(
    .NUM_LANES (NUM_LANES)
  ) i_ad7768_rx (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .drdy       (drdy),
    .lane_data  (lane_data),
    .clr_req    (clr_req),
    .clr_mask   (clr_mask),
    .adc_valid  (adc_valid),
    .adc_sample (adc_sample),
    .ch_status  (ch_status),
    .clr_ack    (clr_ack)
  );

  // ********************
  // helpers
  // ********************

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // taps 32 22 2 1
  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [WORD_W-1:0] make_word(input logic err, input logic [CH_W-1:0] id,
                                                 input logic [DATA_W-1:0] data);
    return {err, 4'h0, id, data};
  endfunction

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected ch %0d data %h, actual ch %0d data %h",
                         name, exp.channel, exp.data, act.channel, act.data));
    end
  endtask

  task automatic check_status(input string name, input int ch, input ch_status_t exp,
                              input ch_status_t act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s ch %0d: expected err %b id_fault %b, actual %b %b",
                         name, ch, exp.err, exp.id_fault, act.err, act.id_fault));
    end
  endtask

  task automatic check_ack(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s clr_ack: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_flags(input string name);
    for (int i = 0; i < NUM_LANES; i++) begin
      check_status(name, i, exp_flags[i], ch_status[i]);
    end
  endtask

  // ********************
  // stimulus table
  // ********************

  task automatic build_table();
    logic [DATA_W-1:0] vals [NUM_LANES];
    vals = '{24'h000001, 24'hffffff, 24'h7fffff, 24'h800000,
             24'h123456, 24'habcdef, 24'h000000, 24'h400000};
    for (int e = 0; e < N_ENTRIES; e++) begin
      table_q[e] = '0;
      table_q[e].len = BIT_CNT_W'(WORD_W);
      for (int l = 0; l < NUM_LANES; l++) begin
        table_q[e].words[l] = (e < N_FIXED) ? make_word(1'b0, CH_W'(l), vals[l])
                                            : rand_bits(WORD_W);
      end
      if (e >= N_FIXED) begin
        names[e] = $sformatf("random_%0d", e - N_FIXED);
        table_q[e].clr_en = e[0];
        table_q[e].clr_mask = NUM_LANES'(rand_bits(NUM_LANES));
      end
    end
    names[0] = "clean_lane_order";
    names[1] = "hdr_err_lane3";
    table_q[1].words[3][HDR_ERR_BIT] = 1'b1;
    names[2] = "id_fault_lane5";
    table_q[2].words[5][HDR_ID_LSB +: CH_W] = 3'd2;
    names[3] = "sticky_then_clear";
    table_q[3].clr_en = 1'b1;
    table_q[3].clr_mask = 8'h08;
    names[4] = "short_frame";
    table_q[4].len = 6'd20;
    names[5] = "full_after_short";
    table_q[5].clr_en = 1'b1;
    table_q[5].clr_mask = 8'h20;
  endtask

  // msb first, then 4 idle cycles with drdy low
  task automatic drive_frame(input entry_t ent);
    for (int b = 0; b < int'(ent.len); b++) begin
      @(posedge adc_clk);
      drdy <= 1'b1;
      for (int l = 0; l < NUM_LANES; l++) begin
        lane_data[l] <= ent.words[l][WORD_W-1-b];
      end
    end
    @(posedge adc_clk);
    drdy      <= 1'b0;
    lane_data <= '0;
    repeat (3) @(posedge adc_clk);
  endtask

  task automatic run_clear(input string name, input logic [NUM_LANES-1:0] mask);
    @(posedge adc_clk);
    clr_mask <= mask;
    clr_req  <= 1'b1;
    @(negedge adc_clk);
    check_ack(name, 1'b0, clr_ack);
    while (!clr_ack) @(negedge adc_clk);
    for (int i = 0; i < NUM_LANES; i++) begin
      if (mask[i]) exp_flags[i] = '0;
    end
    @(negedge adc_clk);
    check_flags(name);
    @(posedge adc_clk);
    clr_req <= 1'b0;
    @(negedge adc_clk);
    check_ack(name, 1'b1, clr_ack);
    while (clr_ack) @(negedge adc_clk);
  endtask

  // ********************
  // monitor and timeout
  // ********************

  always @(posedge adc_clk) begin
    if (adc_valid) sample_q.push_back(adc_sample);
  end

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run("timeout, the run went past its cycle limit");
    end
  end

  initial begin
    sample_t     exp_s;
    entry_t      ent;
    logic [31:0] w;
    arst_n    = 1'b0;
    drdy      = 1'b0;
    lane_data = '0;
    clr_req   = 1'b0;
    clr_mask  = '0;
    build_table();
    for (int i = 0; i < NUM_LANES; i++) exp_flags[i] = '0;
    repeat (8) @(posedge adc_clk);
    arst_n <= 1'b1;
    @(negedge adc_clk);
    if (adc_valid !== 1'b0) begin
      fail_run($sformatf("Mismatch reset adc_valid: expected 0, actual %b", adc_valid));
    end
    check_ack("reset", 1'b0, clr_ack);
    check_flags("reset");
    for (int e = 0; e < N_ENTRIES; e++) begin
      ent = table_q[e];
      if (sample_q.size() != 0) fail_run("samples arrived outside of a frame burst");
      drive_frame(ent);
      if (int'(ent.len) != WORD_W) begin
        repeat (NUM_LANES + 4) @(negedge adc_clk);
        if (sample_q.size() != 0) fail_run({names[e], ": a short frame produced samples"});
      end else begin
        while (sample_q.size() < NUM_LANES) @(negedge adc_clk);
        for (int l = 0; l < NUM_LANES; l++) begin
          w = ent.words[l];
          exp_s.channel = CH_W'(l);
          exp_s.data    = WORD_W'($signed(w[DATA_W-1:0]));
          check_sample(names[e], exp_s, sample_q.pop_front());
          // header rule of the sticky flags
          if (w[HDR_ERR_BIT]) exp_flags[l].err = 1'b1;
          if (w[HDR_ID_LSB +: CH_W] != CH_W'(l)) exp_flags[l].id_fault = 1'b1;
        end
      end
      check_flags(names[e]);
      if (ent.clr_en) run_clear(names[e], ent.clr_mask);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
